// ==== design/cpu_pkg.sv ====
// processor-side constants, redirect kinds, redirect and fetch output structs
package cpu_pkg;

   // data and address width
   localparam int word_w = 16;

   localparam logic [word_w-1:0] reset_pc = '0;

   // shown on fout.instr while no valid instruction is held
   localparam logic [word_w-1:0] nop_instr = 16'b0000_1000_0000_0000;

   // byte step between consecutive instruction words
   localparam logic [word_w-1:0] pc_step = 16'd2;

   typedef enum logic [1:0] {
      seq,
      branch,
      jump_rel,
      jump_reg
   } redirect_kind_t;

   // base is PC+2 of the branch, or the register value for jump_reg
   typedef struct packed {
      logic              valid;
      redirect_kind_t    kind;
      logic              taken;
      logic [word_w-1:0] base;
      logic [word_w-1:0] offset;
   } redirect_t;

   typedef struct packed {
      logic              valid;
      logic [word_w-1:0] instr;
      logic [word_w-1:0] pc_2;
   } fetch_out_t;

endpackage

// ==== design/bus_pkg.sv ====
// Wishbone classic request and response structs, memory size constants
package bus_pkg;

   import cpu_pkg::*;

   // word count of the unified memory
   localparam int mem_words = 256;

   // word index width, taken from address bits above bit 0
   localparam int mem_aw = $clog2(mem_words);

   typedef struct packed {
      logic              cyc;
      logic              stb;
      logic              we;
      logic [word_w-1:0] adr;
      logic [word_w-1:0] dat;
   } wb_req_t;

   // err is raised instead of ack for odd byte addresses
   typedef struct packed {
      logic              ack;
      logic              err;
      logic [word_w-1:0] dat;
   } wb_rsp_t;

endpackage

// ==== design/fetch.sv ====
// fetch stage: program counter, next-address select, instruction read master, output register
`timescale 1ns/1ns
module fetch
   import cpu_pkg::*, bus_pkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  redirect_t  redirect,
   input  logic       hazard,
   input  logic       halt,
   input  wb_rsp_t    bus_rsp,
   output wb_req_t    bus_req,
   output fetch_out_t fout,
   output logic       align_err
);

   typedef enum logic [1:0] {
      st_idle,
      st_wait,
      st_hold
   } fetch_state_t;

   fetch_state_t      state;
   // address of the instruction in flight or held, next one to read when idle
   logic [word_w-1:0] pc;
   logic [word_w-1:0] pc_2;
   logic [word_w-1:0] base_tgt;
   logic [word_w-1:0] rel_tgt;
   logic [word_w-1:0] tgt_pc;
   logic              take;
   // outstanding read was overtaken by a redirect
   logic              drop;
   logic              cyc_q;
   logic [word_w-1:0] adr_q;
   fetch_out_t        fout_q;

   assign pc_2 = pc + pc_step;

   // branch and register jump both add the offset to the supplied base
   assign base_tgt = redirect.base + redirect.offset;
   // relative jump counts from the word after the current pc
   assign rel_tgt = pc_2 + redirect.offset;

   // not-taken branches fall through untouched
   assign take = redirect.valid & redirect.taken;

   always_comb begin
      case (redirect.kind)
         branch, jump_reg: tgt_pc = base_tgt;
         jump_rel:         tgt_pc = rel_tgt;
         default:          tgt_pc = pc_2;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= st_idle;
         pc           <= reset_pc;
         cyc_q        <= 1'b0;
         drop         <= 1'b0;
         align_err    <= 1'b0;
         fout_q.valid <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               if (take) begin
                  pc <= tgt_pc;
               end
               // a halt freezes the pc here, an alignment error parks fetch for good
               if (!halt && !align_err) begin
                  cyc_q <= 1'b1;
                  adr_q <= take ? tgt_pc : pc;
                  state <= st_wait;
               end
            end
            st_wait: begin
               if (take) begin
                  pc <= tgt_pc;
               end
               drop <= drop | take;
               if (bus_rsp.err) begin
                  cyc_q     <= 1'b0;
                  drop      <= 1'b0;
                  align_err <= 1'b1;
                  state     <= st_idle;
               end else if (bus_rsp.ack) begin
                  cyc_q <= 1'b0;
                  drop  <= 1'b0;
                  // overtaken data is thrown away, idle restarts from the new pc
                  if (drop || take) begin
                     state <= st_idle;
                  end else begin
                     fout_q.valid <= 1'b1;
                     fout_q.instr <= bus_rsp.dat;
                     fout_q.pc_2  <= pc_2;
                     state        <= st_hold;
                  end
               end
            end
            st_hold: begin
               // redirect flushes the held word, otherwise wait for consumption
               if (take || !hazard) begin
                  fout_q.valid <= 1'b0;
                  pc           <= take ? tgt_pc : pc_2;
                  if (!halt) begin
                     cyc_q <= 1'b1;
                     adr_q <= take ? tgt_pc : pc_2;
                     state <= st_wait;
                  end else begin
                     state <= st_idle;
                  end
               end
            end
            default: state <= st_idle;
         endcase
      end
   end

   // instruction reads only
   assign bus_req = '{cyc: cyc_q, stb: cyc_q, we: 1'b0, adr: adr_q, dat: '0};

   assign fout = '{valid: fout_q.valid,
                   instr: fout_q.valid ? fout_q.instr : nop_instr,
                   pc_2:  fout_q.pc_2};

endmodule

// ==== design/data_port.sv ====
// data port: load/store requests from the memory stage as Wishbone master cycles
`timescale 1ns/1ns
module data_port
   import cpu_pkg::*, bus_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              dreq_valid,
   input  logic              dreq_we,
   input  logic [word_w-1:0] dreq_addr,
   input  logic [word_w-1:0] dreq_wdata,
   input  wb_rsp_t           bus_rsp,
   output wb_req_t           bus_req,
   output logic [word_w-1:0] drdata,
   output logic              ddone
);

   logic done_beat;

   // an err ends a data access the same way an ack does
   assign done_beat = bus_req.cyc & (bus_rsp.ack | bus_rsp.err);

   always_ff @(posedge clk) begin
      if (rst) begin
         bus_req.cyc <= 1'b0;
         bus_req.stb <= 1'b0;
         ddone       <= 1'b0;
      end else begin
         ddone <= done_beat;
         if (done_beat) begin
            bus_req.cyc <= 1'b0;
            bus_req.stb <= 1'b0;
         end else if (!bus_req.cyc && dreq_valid) begin
            // latch the request, anything arriving while busy is dropped
            bus_req.cyc <= 1'b1;
            bus_req.stb <= 1'b1;
            bus_req.we  <= dreq_we;
            bus_req.adr <= dreq_addr;
            bus_req.dat <= dreq_wdata;
         end
      end
   end

   // load data lines up with the ddone pulse
   always_ff @(posedge clk) begin
      if (done_beat) begin
         drdata <= bus_rsp.dat;
      end
   end

endmodule

// ==== design/mem_arbiter.sv ====
// two-master Wishbone classic arbiter, data port first, grant locked per cycle
`timescale 1ns/1ns
module mem_arbiter
   import bus_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  wb_req_t m_fetch_req,
   input  wb_req_t m_data_req,
   input  wb_rsp_t s_rsp,
   output wb_req_t s_req,
   output wb_rsp_t m_fetch_rsp,
   output wb_rsp_t m_data_rsp
);

   logic gnt_fetch;
   logic gnt_data;
   logic bus_free;

   // owner lets go once it drops cyc
   assign bus_free = ~((gnt_fetch & m_fetch_req.cyc) | (gnt_data & m_data_req.cyc));

   always_ff @(posedge clk) begin
      if (rst) begin
         gnt_fetch <= 1'b0;
         gnt_data  <= 1'b0;
      end else if (bus_free) begin
         gnt_data  <= m_data_req.cyc;
         gnt_fetch <= m_fetch_req.cyc & ~m_data_req.cyc;
      end
   end

   always_comb begin
      if (gnt_data) begin
         s_req = m_data_req;
      end else if (gnt_fetch) begin
         s_req = m_fetch_req;
      end else begin
         s_req = '0;
      end
   end

   // read data goes to both, handshake only to the owner
   always_comb begin
      m_fetch_rsp     = s_rsp;
      m_fetch_rsp.ack = s_rsp.ack & gnt_fetch;
      m_fetch_rsp.err = s_rsp.err & gnt_fetch;
      m_data_rsp      = s_rsp;
      m_data_rsp.ack  = s_rsp.ack & gnt_data;
      m_data_rsp.err  = s_rsp.err & gnt_data;
   end

endmodule

// ==== design/unified_mem.sv ====
// unified instruction and data word RAM, Wishbone slave with one wait state
`timescale 1ns/1ns
module unified_mem
   import cpu_pkg::*, bus_pkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  wb_req_t req,
   output wb_rsp_t rsp
);

   logic [word_w-1:0] ram [mem_words];
   logic [mem_aw-1:0] idx;
   logic              sel;
   logic              first;
   logic              ack_q;
   logic              err_q;
   logic [word_w-1:0] dat_q;

   // byte address to word index, upper bits are ignored
   assign idx = req.adr[mem_aw:1];
   assign sel = req.cyc & req.stb;

   // only the first sampled cycle of an access starts a response
   assign first = sel & ~ack_q & ~err_q;

   always_ff @(posedge clk) begin
      if (rst) begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
      end else begin
         ack_q <= first & ~req.adr[0];
         err_q <= first & req.adr[0];
      end
   end

   always_ff @(posedge clk) begin
      if (first) begin
         dat_q <= ram[idx];
      end
      // write lands on the ack cycle
      if (ack_q && sel && req.we) begin
         ram[idx] <= req.dat;
      end
   end

   // response falls as soon as stb goes low
   assign rsp.ack = ack_q & sel;
   assign rsp.err = err_q & sel;
   assign rsp.dat = dat_q;

endmodule

// ==== design/fetch_mem_top.sv ====
// top level: fetch, data port, arbiter and unified memory
`timescale 1ns/1ns
module fetch_mem_top
   import cpu_pkg::*, bus_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  redirect_t         redirect,
   input  logic              hazard,
   input  logic              halt,
   input  logic              dreq_valid,
   input  logic              dreq_we,
   input  logic [word_w-1:0] dreq_addr,
   input  logic [word_w-1:0] dreq_wdata,
   output fetch_out_t        fout,
   output logic              align_err,
   output logic [word_w-1:0] drdata,
   output logic              ddone
);

   wb_req_t fetch_req;
   wb_rsp_t fetch_rsp;
   wb_req_t data_req;
   wb_rsp_t data_rsp;
   wb_req_t mem_req;
   wb_rsp_t mem_rsp;

   fetch i_fetch (
      .clk       (clk),
      .rst       (rst),
      .redirect  (redirect),
      .hazard    (hazard),
      .halt      (halt),
      .bus_rsp   (fetch_rsp),
      .bus_req   (fetch_req),
      .fout      (fout),
      .align_err (align_err)
   );

   data_port i_data_port (
      .clk        (clk),
      .rst        (rst),
      .dreq_valid (dreq_valid),
      .dreq_we    (dreq_we),
      .dreq_addr  (dreq_addr),
      .dreq_wdata (dreq_wdata),
      .bus_rsp    (data_rsp),
      .bus_req    (data_req),
      .drdata     (drdata),
      .ddone      (ddone)
   );

   mem_arbiter i_mem_arbiter (
      .clk         (clk),
      .rst         (rst),
      .m_fetch_req (fetch_req),
      .m_data_req  (data_req),
      .s_rsp       (mem_rsp),
      .s_req       (mem_req),
      .m_fetch_rsp (fetch_rsp),
      .m_data_rsp  (data_rsp)
   );

   unified_mem i_unified_mem (
      .clk (clk),
      .rst (rst),
      .req (mem_req),
      .rsp (mem_rsp)
   );

endmodule

// ==== verification/fetch_chk.sv ====
// bound assertions for request stability up to ack or err and flags low after reset
`timescale 1ns/1ns
module fetch_chk
   import bus_pkg::*;
(
   input logic    clk,
   input logic    rst,
   input wb_req_t req,
   input wb_rsp_t rsp,
   input logic    low_after_rst
);

   // request held until the slave answers
   req_stable: assert property (@(posedge clk) disable iff (rst)
      req.cyc && req.stb && !rsp.ack && !rsp.err
      |=> req.cyc && req.stb && $stable({req.we, req.adr, req.dat}))
      else $error("request changed before ack or err");

   low_after_reset: assert property (@(posedge clk) rst |=> !low_after_rst)
      else $error("flag high right after reset");

endmodule

// on the memory side a steady request means one owner for the whole cycle
bind mem_arbiter fetch_chk i_arb_chk (
   .clk (clk), .rst (rst), .req (s_req), .rsp (s_rsp),
   .low_after_rst (gnt_fetch | gnt_data)
);

bind fetch fetch_chk i_fetch_chk (
   .clk (clk), .rst (rst), .req (bus_req), .rsp (bus_rsp),
   .low_after_rst (fout.valid)
);

// ==== verification/fetch_tb.sv ====
// fetch stage testbench: clock, reset, LFSR stimulus, pc and memory model, checks, timeout
`timescale 1ns/1ns
module fetch_tb
   import cpu_pkg::*, bus_pkg::*;
();

   localparam int n_prog  = 128;
   localparam int n_seq   = 32;
   localparam int n_redir = 48;
   localparam int n_mix   = 64;
   // one operation per data access, fetched instruction, halt test and error test
   localparam int cycle_limit = 40 * (2 * n_prog + n_seq + n_redir + n_mix + 2);

   logic              clk;
   logic              rst = 1'b1;
   redirect_t         redirect = '0;
   logic              hazard = 1'b0;
   logic              halt = 1'b1;
   logic              dreq_valid = 1'b0;
   logic              dreq_we = 1'b0;
   logic [word_w-1:0] dreq_addr = '0;
   logic [word_w-1:0] dreq_wdata = '0;
   fetch_out_t        fout;
   logic              align_err;
   logic [word_w-1:0] drdata;
   logic              ddone;

   // values applied at the next rising edge
   logic              nx_rst = 1'b1;
   redirect_t         nx_redirect = '0;
   logic              nx_hazard = 1'b0;
   logic              nx_halt = 1'b1;
   logic              nx_dvalid = 1'b0;
   logic              nx_dwe = 1'b0;
   logic [15:0]       nx_daddr = '0;
   logic [15:0]       nx_dwdata = '0;

   logic [15:0]       model_mem [mem_words];
   // address of the instruction fetch shows or reads next
   logic [15:0]       exp_pc = '0;
   logic [15:0]       rd_exp = '0;
   logic              rd_check = 1'b0;
   logic              busy = 1'b0;
   int                issued = 0;
   int                ddone_cnt = 0;
   int                consumed = 0;
   int                cycles = 0;
   logic [15:0]       lfsr = 16'(79800);

   fetch_mem_top i_fetch_mem_top (.*);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("TEST RESULT: FAIL");
         $fatal(1, "timeout, the run did not finish within %0d cycles", cycle_limit);
      end
   end

   // feedback taps of x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] rnd(input int n);
      logic [15:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
         v = {v[14:0], lfsr[0]};
      end
      return v;
   endfunction

   task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
      if (exp !== act) begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         $display("TEST RESULT: FAIL");
         $fatal(1, "value mismatch in %s", name);
      end
   endtask

   // outputs and inputs are both settled at the falling edge
   task automatic observe();
      if (ddone === 1'b1) begin
         ddone_cnt++;
         busy = 1'b0;
         if (rd_check) begin
            check_eq("data_readback", rd_exp, drdata);
         end
         rd_check = 1'b0;
      end
      if (fout.valid === 1'b1) begin
         check_eq("fetch_instr", model_mem[exp_pc[8:1]], fout.instr);
         check_eq("fetch_pc_2", exp_pc + 16'd2, fout.pc_2);
      end
      // a taken redirect wins over consumption of the held word
      if (redirect.valid === 1'b1 && redirect.taken === 1'b1) begin
         if (redirect.kind == jump_rel) begin
            exp_pc = exp_pc + 16'd2 + redirect.offset;
         end else begin
            exp_pc = redirect.base + redirect.offset;
         end
      end else if (fout.valid === 1'b1 && hazard === 1'b0) begin
         exp_pc = exp_pc + 16'd2;
         consumed++;
      end
   endtask

   task automatic tick();
      @(posedge clk);
      rst        <= nx_rst;
      redirect   <= nx_redirect;
      hazard     <= nx_hazard;
      halt       <= nx_halt;
      dreq_valid <= nx_dvalid;
      dreq_we    <= nx_dwe;
      dreq_addr  <= nx_daddr;
      dreq_wdata <= nx_dwdata;
      @(negedge clk);
      observe();
      nx_redirect.valid = 1'b0;
      nx_dvalid = 1'b0;
   endtask

   task automatic apply_reset();
      nx_rst = 1'b1;
      nx_halt = 1'b1;
      repeat (5) tick();
      nx_rst = 1'b0;
      exp_pc = 16'h0000;
   endtask

   task automatic start_data(input logic we, input logic [15:0] addr, input logic [15:0] wdata);
      nx_dvalid = 1'b1;
      nx_dwe = we;
      nx_daddr = addr;
      nx_dwdata = wdata;
      busy = 1'b1;
      issued++;
      rd_check = !we;
      if (we) begin
         model_mem[addr[8:1]] = wdata;
      end else begin
         rd_exp = model_mem[addr[8:1]];
      end
   endtask

   task automatic data_access(input logic we, input logic [15:0] addr, input logic [15:0] wdata);
      start_data(we, addr, wdata);
      tick();
      while (busy) tick();
      check_eq("ddone_count", 16'(issued), 16'(ddone_cnt));
   endtask

   initial begin
      logic [15:0]    r;
      logic [15:0]    tgt;
      redirect_kind_t kind;
      int             mark;
      int             shown;
      apply_reset();
      // program region is words 0 to 127 while halt keeps fetch idle
      for (int i = 0; i < n_prog; i++) begin
         data_access(1'b1, 16'(2 * i), rnd(16));
      end
      for (int i = 0; i < n_prog; i++) begin
         data_access(1'b0, 16'(2 * i), 16'h0000);
      end
      nx_halt = 1'b0;
      while (consumed < n_seq) tick();
      // short gaps put many redirects on top of an outstanding read
      for (int i = 0; i < n_redir; i++) begin
         repeat (rnd(2)) tick();
         r = rnd(2);
         kind = (r[1:0] == 2'd0) ? branch : redirect_kind_t'(r[1:0]);
         tgt = rnd(6) << 1;
         r = rnd(16);
         nx_redirect.valid = 1'b1;
         nx_redirect.kind = kind;
         nx_redirect.taken = (kind != branch) || (rnd(2) != 16'd0);
         nx_redirect.base = r;
         nx_redirect.offset = (kind == jump_rel) ? tgt - exp_pc - 16'd2 : tgt - r;
         mark = consumed;
         tick();
         while (consumed == mark) tick();
      end
      // stalls and data writes above the program region while fetching
      mark = consumed + n_mix;
      while (consumed < mark) begin
         nx_hazard = (rnd(2) == 16'd0);
         if (exp_pc >= 16'h00f0) begin
            nx_redirect = '{valid: 1'b1, kind: jump_reg, taken: 1'b1,
                            base: rnd(6) << 1, offset: 16'h0000};
         end
         if (!busy && rnd(1) == 16'd1) begin
            start_data(1'b1, 16'h0100 | (rnd(7) << 1), rnd(16));
         end
         tick();
      end
      nx_hazard = 1'b0;
      while (busy) tick();
      check_eq("ddone_count", 16'(issued), 16'(ddone_cnt));
      nx_halt = 1'b1;
      shown = 0;
      repeat (6) begin
         tick();
         if (fout.valid === 1'b1) shown++;
      end
      check_eq("halt_more_than_one", 16'd0, 16'(shown > 1));
      repeat (20) begin
         tick();
         check_eq("halt_valid", 16'd0, 16'(fout.valid));
         check_eq("halt_instr", nop_instr, fout.instr);
      end
      apply_reset();
      r = rnd(16);
      tgt = rnd(16) | 16'h0001;
      nx_redirect = '{valid: 1'b1, kind: jump_reg, taken: 1'b1, base: tgt - r, offset: r};
      nx_halt = 1'b0;
      tick();
      while (align_err !== 1'b1) tick();
      // even target that only a parked fetch leaves unread
      nx_redirect = '{valid: 1'b1, kind: jump_reg, taken: 1'b1,
                      base: rnd(6) << 1, offset: 16'h0000};
      repeat (20) begin
         tick();
         check_eq("err_valid", 16'd0, 16'(fout.valid));
         check_eq("err_sticky", 16'd1, 16'(align_err));
      end
      check_eq("ddone_count", 16'(issued), 16'(ddone_cnt));
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== list.f ====
design/cpu_pkg.sv
design/bus_pkg.sv
design/fetch.sv
design/data_port.sv
design/mem_arbiter.sv
design/unified_mem.sv
design/fetch_mem_top.sv
verification/fetch_chk.sv
verification/fetch_tb.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --timescale 1ns/1ns \
   --top-module fetch_tb -f list.f -o fetch_sim &&
./obj_dir/fetch_sim || exit 1
